/* wb_settings.svh */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// ######################################################################
// datapath sizes
// ######################################################################

`define XLEN 64            // data and pc width.
`define NREG 32            // integer register count.

// ######################################################################
// iterative unit step counts
// ######################################################################

`define MUL_STEPS 64       // one multiplier bit per cycle.
`define DIV_STEPS 64       // one quotient bit per cycle.

`endif

/* wb_pkg.sv */
package wb_pkg;

    // ######################################################################
    // unit opcodes
    // ######################################################################

    typedef enum logic {
        MUL_LO = 1'b0,     // low half of product.
        MUL_HU = 1'b1      // high half, unsigned.
    } mul_op_e;

    typedef enum logic {
        DIV_QU = 1'b0,     // unsigned quotient.
        DIV_RU = 1'b1      // unsigned remainder.
    } div_op_e;

    // shared by the multiplier and the divider.
    typedef enum logic [1:0] {
        U_IDLE = 2'd0,
        U_RUN  = 2'd1,
        U_HOLD = 2'd2
    } unit_state_e;

endpackage

/* wb_src_if.sv */
`include "wb_settings.svh"

// one functional unit result heading for writeback.
interface wb_src_if;
    logic              wen;     // single-cycle result pulse.
    logic [4:0]        rd;
    logic [`XLEN-1:0]  data;
    logic [`XLEN-1:0]  pc;
    logic              block;   // stage entry still pending.

    modport unit (
        output wen, rd, data, pc,
        input  block
    );

    modport arb (
        input  wen, rd, data, pc,
        output block
    );

endinterface

/* mul_unit.sv */
`include "wb_settings.svh"

module mul_unit import wb_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  mul_op_e           op,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  logic [4:0]        rd,
    input  logic [`XLEN-1:0]  pc,
    output logic              busy,
    wb_src_if.unit            wb
);
    localparam int STEP_W = $clog2(`MUL_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`MUL_STEPS - 1);

    unit_state_e          state;
    logic [STEP_W-1:0]    step;
    logic [2*`XLEN-1:0]   acc;      // {high partial, remaining multiplier}.
    logic [`XLEN-1:0]     mcand;
    logic [`XLEN:0]       sum;      // carry out kept for the shift.
    mul_op_e              op_q;
    logic [4:0]           rd_q;
    logic [`XLEN-1:0]     pc_q;

    assign sum = {1'b0, acc[2*`XLEN-1:`XLEN]} + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= U_IDLE;
            step  <= '0;
        end else begin
            case (state)
                U_IDLE: if (start) begin
                    state <= U_RUN;
                    step  <= '0;
                end
                U_RUN: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) state <= U_HOLD;
                end
                U_HOLD: if (!wb.block) state <= U_IDLE;   // pulse taken.
                default: state <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == U_IDLE && start) begin
            acc   <= {{`XLEN{1'b0}}, b};
            mcand <= a;
            op_q  <= op;
            rd_q  <= rd;
            pc_q  <= pc;
        end else if (state == U_RUN) begin
            acc <= {sum, acc[`XLEN-1:1]};
        end
    end

    assign busy    = (state != U_IDLE);
    assign wb.wen  = (state == U_HOLD) && !wb.block;
    assign wb.rd   = rd_q;
    assign wb.pc   = pc_q;
    assign wb.data = (op_q == MUL_HU) ? acc[2*`XLEN-1:`XLEN] : acc[`XLEN-1:0];

    // issue logic upstream must wait for the previous result.
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

/* div_unit.sv */
`include "wb_settings.svh"

module div_unit import wb_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  div_op_e           op,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  logic [4:0]        rd,
    input  logic [`XLEN-1:0]  pc,
    output logic              busy,
    wb_src_if.unit            wb
);
    localparam int STEP_W = $clog2(`DIV_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`DIV_STEPS - 1);

    unit_state_e          state;
    logic [STEP_W-1:0]    step;
    logic [`XLEN-1:0]     rem_q;
    logic [`XLEN-1:0]     quo_q;    // dividend bits shift out as quotient bits enter.
    logic [`XLEN-1:0]     dvs_q;
    logic [`XLEN:0]       shifted;
    logic [`XLEN:0]       diff;
    div_op_e              op_q;
    logic [4:0]           rd_q;
    logic [`XLEN-1:0]     pc_q;

    // with a zero divisor every trial succeeds, so the quotient fills with
    // ones and the remainder collects the dividend, as RISC-V requires.
    assign shifted = {rem_q, quo_q[`XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= U_IDLE;
            step  <= '0;
        end else begin
            case (state)
                U_IDLE: if (start) begin
                    state <= U_RUN;
                    step  <= '0;
                end
                U_RUN: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) state <= U_HOLD;
                end
                U_HOLD: if (!wb.block) state <= U_IDLE;
                default: state <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == U_IDLE && start) begin
            rem_q <= '0;
            quo_q <= a;
            dvs_q <= b;
            op_q  <= op;
            rd_q  <= rd;
            pc_q  <= pc;
        end else if (state == U_RUN) begin
            if (!diff[`XLEN]) begin                      // trial fits.
                rem_q <= diff[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin                               // restore.
                rem_q <= shifted[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    assign busy    = (state != U_IDLE);
    assign wb.wen  = (state == U_HOLD) && !wb.block;
    assign wb.rd   = rd_q;
    assign wb.pc   = pc_q;
    assign wb.data = (op_q == DIV_RU) ? rem_q : quo_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

/* wb_arbiter.sv */
`include "wb_settings.svh"

module wb_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic              m_wen,
    input  logic              m_mem_rd,
    input  logic [4:0]        m_rd,
    input  logic [`XLEN-1:0]  m_data,
    input  logic [`XLEN-1:0]  m_pc,
    input  logic              m_error,
    input  logic [`XLEN-1:0]  data_rd,
    input  logic              data_rd_valid,
    input  logic              data_rd_error,
    output logic              m_block,
    wb_src_if.arb             mul_wb,
    wb_src_if.arb             div_wb,
    output logic              commit_valid,
    output logic [4:0]        commit_rd,
    output logic [`XLEN-1:0]  commit_data,
    output logic [`XLEN-1:0]  commit_pc,
    output logic              commit_error
);
    // ######################################################################
    // stage entries
    // ######################################################################

    logic mem_v, mem_load, mem_err;
    logic [4:0] mem_rd;
    logic [`XLEN-1:0] mem_data, mem_pc;
    logic div_v, mul_v;
    logic [4:0] div_rd, mul_rd;
    logic [`XLEN-1:0] div_data, div_pc, mul_data, mul_pc;
    logic mem_ready, sel_mem, sel_div, sel_mul;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_v <= 1'b0;
            div_v <= 1'b0;
            mul_v <= 1'b0;
        end else begin
            mem_v <= m_wen      || (mem_v && !sel_mem);
            div_v <= div_wb.wen || (div_v && !sel_div);
            mul_v <= mul_wb.wen || (mul_v && !sel_mul);
        end
    end

    always_ff @(posedge clk) begin
        if (m_wen) begin
            mem_load <= m_mem_rd;
            mem_err  <= m_error;
            mem_rd   <= m_rd;
            mem_data <= m_data;
            mem_pc   <= m_pc;
        end
        if (div_wb.wen) begin
            div_rd   <= div_wb.rd;
            div_data <= div_wb.data;
            div_pc   <= div_wb.pc;
        end
        if (mul_wb.wen) begin
            mul_rd   <= mul_wb.rd;
            mul_data <= mul_wb.data;
            mul_pc   <= mul_wb.pc;
        end
    end

    // ######################################################################
    // priority select and commit
    // ######################################################################

    assign mem_ready = mem_v && (!mem_load || data_rd_valid);   // load waits for data.
    assign sel_mem   = mem_ready;
    assign sel_div   = div_v && !mem_ready;
    assign sel_mul   = mul_v && !mem_ready && !div_v;

    assign m_block      = mem_v && !sel_mem;
    assign div_wb.block = div_v && !sel_div;
    assign mul_wb.block = mul_v && !sel_mul;

    assign commit_valid = sel_mem || sel_div || sel_mul;

    always_comb begin
        if (sel_mem) begin
            commit_rd    = mem_rd;
            commit_data  = mem_load ? data_rd : mem_data;
            commit_pc    = mem_pc;
            commit_error = mem_err || (mem_load && data_rd_error);
        end else if (sel_div) begin
            commit_rd    = div_rd;
            commit_data  = div_data;
            commit_pc    = div_pc;
            commit_error = 1'b0;        // units raise no faults.
        end else begin
            commit_rd    = mul_rd;
            commit_data  = mul_data;
            commit_pc    = mul_pc;
            commit_error = 1'b0;
        end
    end

    a_mem_no_overrun: assert property (@(posedge clk) disable iff (reset) m_block |-> !m_wen);
    a_div_no_overrun: assert property (@(posedge clk) disable iff (reset) div_wb.block |-> !div_wb.wen);
    a_mul_no_overrun: assert property (@(posedge clk) disable iff (reset) mul_wb.block |-> !mul_wb.wen);

    // a committed entry stays only when its producer refilled it.
    a_mem_commit_once: assert property (@(posedge clk) disable iff (reset)
        sel_mem |=> !mem_v || $past(m_wen));
    a_div_commit_once: assert property (@(posedge clk) disable iff (reset)
        sel_div |=> !div_v || $past(div_wb.wen));
    a_mul_commit_once: assert property (@(posedge clk) disable iff (reset)
        sel_mul |=> !mul_v || $past(mul_wb.wen));

endmodule

/* regfile.sv */
`include "wb_settings.svh"

module regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic              wen,
    input  logic [4:0]        waddr,
    input  logic [`XLEN-1:0]  wdata,
    input  logic [4:0]        raddr,
    output logic [`XLEN-1:0]  rdata
);
    logic [`XLEN-1:0] regs [`NREG];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin   // x0 stays zero.
            regs[waddr] <= wdata;
        end
    end

    // observation port.
    assign rdata = regs[raddr];

endmodule

/* wb_top.sv */
`include "wb_settings.svh"

module wb_top import wb_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // memory stage
    input  logic              m_wen,
    input  logic              m_mem_rd,
    input  logic [4:0]        m_rd,
    input  logic [`XLEN-1:0]  m_data,
    input  logic [`XLEN-1:0]  m_pc,
    input  logic              m_error,
    input  logic [`XLEN-1:0]  data_rd,
    input  logic              data_rd_valid,
    input  logic              data_rd_error,
    output logic              m_block,
    // multiplier
    input  logic              mul_start,
    input  mul_op_e           mul_op,
    input  logic [`XLEN-1:0]  mul_a,
    input  logic [`XLEN-1:0]  mul_b,
    input  logic [4:0]        mul_rd,
    input  logic [`XLEN-1:0]  mul_pc,
    output logic              mul_busy,
    // divider
    input  logic              div_start,
    input  div_op_e           div_op,
    input  logic [`XLEN-1:0]  div_a,
    input  logic [`XLEN-1:0]  div_b,
    input  logic [4:0]        div_rd,
    input  logic [`XLEN-1:0]  div_pc,
    output logic              div_busy,
    // commit
    output logic              commit_valid,
    output logic [4:0]        commit_rd,
    output logic [`XLEN-1:0]  commit_data,
    output logic [`XLEN-1:0]  commit_pc,
    output logic              commit_error,
    input  logic [4:0]        rs_addr,
    output logic [`XLEN-1:0]  rs_data
);
    wb_src_if i_mul_if ();
    wb_src_if i_div_if ();

    mul_unit i_mul (
        .clk(clk), .reset(reset), .start(mul_start), .op(mul_op), .a(mul_a), .b(mul_b),
        .rd(mul_rd), .pc(mul_pc), .busy(mul_busy), .wb(i_mul_if)
    );

    div_unit i_div (
        .clk(clk), .reset(reset), .start(div_start), .op(div_op), .a(div_a), .b(div_b),
        .rd(div_rd), .pc(div_pc), .busy(div_busy), .wb(i_div_if)
    );

    wb_arbiter i_arb (
        .clk(clk), .reset(reset),
        .m_wen(m_wen), .m_mem_rd(m_mem_rd), .m_rd(m_rd), .m_data(m_data), .m_pc(m_pc),
        .m_error(m_error), .data_rd(data_rd), .data_rd_valid(data_rd_valid),
        .data_rd_error(data_rd_error), .m_block(m_block),
        .mul_wb(i_mul_if), .div_wb(i_div_if),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
        .commit_pc(commit_pc), .commit_error(commit_error)
    );

    regfile i_rf (
        .clk(clk), .reset(reset),
        .wen(commit_valid && !commit_error),   // faulted results are dropped.
        .waddr(commit_rd), .wdata(commit_data),
        .raddr(rs_addr), .rdata(rs_data)
    );

endmodule

/* tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // period of 4.
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(negedge clk);  // three full cycles.
        reset = 1'b0;
    end

endmodule

/* tb_wb.sv */
`include "wb_settings.svh"

module tb_wb import wb_pkg::*; ();
    localparam int MAX_CYCLES = 20000;

    logic clk, reset;
    logic m_wen, m_mem_rd, m_error, data_rd_valid, data_rd_error, m_block;
    logic [4:0] m_rd, mul_rd, div_rd, rs_addr, commit_rd;
    logic [`XLEN-1:0] m_data, m_pc, data_rd, mul_a, mul_b, mul_pc, div_a, div_b, div_pc;
    logic [`XLEN-1:0] commit_data, commit_pc, rs_data;
    logic mul_start, div_start, mul_busy, div_busy, commit_valid, commit_error;
    mul_op_e mul_op;
    div_op_e div_op;

    logic [69:0] sb [logic [`XLEN-1:0]];    // {rd, data, error} by pc.
    logic [`XLEN-1:0] shadow [`NREG];       // expected register contents.
    logic [`XLEN-1:0] commit_log [$];
    logic [`XLEN-1:0] next_pc;
    logic [4:0] e_rd;
    logic [`XLEN-1:0] e_data;
    logic e_err;
    int mismatches = 0;
    int failures = 0;
    int cycles = 0;

    tb_clock i_clk (.clk(clk), .reset(reset));
    wb_top i_dut (.*);

    // ######################################################################
    // reference model and helpers
    // ######################################################################

    function automatic logic [`XLEN-1:0] ref_result(input logic is_div, input logic sel,
                                                    input logic [`XLEN-1:0] a, b);
        logic [2*`XLEN-1:0] prod;
        prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        if (!is_div) return sel ? prod[2*`XLEN-1:`XLEN] : prod[`XLEN-1:0];
        if (b == '0) return sel ? a : '1;  // zero divisor.
        return sel ? a % b : a / b;
    endfunction

    function automatic logic [`XLEN-1:0] rand_word();
        return {$urandom(), $urandom()};
    endfunction

    task automatic expect_commit(input logic [4:0] rd, input logic [`XLEN-1:0] data, pc,
                                 input logic err);
        sb[pc] = {rd, data, err};
        next_pc = next_pc + 4;
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] got, expected);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_idle();
        if ({commit_valid, m_block, mul_busy, div_busy} !== 4'b0) begin
            failures++;
            $display("outputs active around reset: valid %b block %b mul %b div %b",
                     commit_valid, m_block, mul_busy, div_busy);
        end
    endtask

    task automatic wait_drain();
        int waited = 0;
        while ((sb.num() != 0 || mul_busy || div_busy) && waited < 300) begin
            @(negedge clk);
            waited++;
        end
        if (sb.num() != 0) begin
            failures++;
            $display("%0d expected commits never arrived", sb.num());
            sb.delete();
        end
    endtask

    task automatic issue_mul();
        while (mul_busy) @(negedge clk);
        mul_start = 1'b1;
        mul_op = mul_op_e'($urandom_range(1, 0));
        mul_a = rand_word();
        mul_b = rand_word();
        mul_rd = 5'($urandom());
        mul_pc = next_pc;
        expect_commit(mul_rd, ref_result(1'b0, mul_op, mul_a, mul_b), mul_pc, 1'b0);
        @(negedge clk);
        mul_start = 1'b0;
    endtask

    task automatic issue_div(input logic [`XLEN-1:0] divisor);
        while (div_busy) @(negedge clk);
        div_start = 1'b1;
        div_op = div_op_e'($urandom_range(1, 0));
        div_a = rand_word();
        div_b = divisor;
        div_rd = 5'($urandom());
        div_pc = next_pc;
        expect_commit(div_rd, ref_result(1'b1, div_op, div_a, div_b), div_pc, 1'b0);
        @(negedge clk);
        div_start = 1'b0;
    endtask

    task automatic issue_mem(input logic load, input int delay);
        logic [`XLEN-1:0] value;
        logic err, rd_err;
        while (m_block) @(negedge clk);
        value = rand_word();
        err = ($urandom_range(3, 0) == 0);
        rd_err = load && ($urandom_range(3, 0) == 0);
        m_wen = 1'b1;
        m_mem_rd = load;
        m_rd = 5'($urandom());
        m_data = load ? rand_word() : value;   // a load takes data_rd instead.
        m_pc = next_pc;
        m_error = err;
        expect_commit(m_rd, value, m_pc, err || rd_err);
        @(negedge clk);
        m_wen = 1'b0;
        if (load) begin
            repeat (delay) begin
                if (m_block !== 1'b1) begin
                    failures++;
                    $display("m_block low while a load waits for its data");
                end
                @(negedge clk);
            end
            data_rd_valid = 1'b1;
            data_rd = value;
            data_rd_error = rd_err;
            @(negedge clk);
            data_rd_valid = 1'b0;
        end
    endtask

    // mul, div and mem results all land in the stage in one cycle.
    task automatic contention_round();
        wait_drain();
        commit_log.delete();
        issue_div_and_mul_together();
        repeat (64) @(negedge clk);
        m_wen = 1'b1;
        m_mem_rd = 1'b0;
        m_error = 1'b0;
        m_rd = 5'($urandom());
        m_data = rand_word();
        m_pc = next_pc;
        expect_commit(m_rd, m_data, m_pc, 1'b0);
        @(negedge clk);
        m_wen = 1'b0;
        wait_drain();
        if (commit_log.size() != 3 || commit_log[0] !== m_pc || commit_log[1] !== div_pc
            || commit_log[2] !== mul_pc) begin
            failures++;
            $display("commit order under contention is not mem, div, mul (%0d commits)",
                     commit_log.size());
        end
    endtask

    task automatic issue_div_and_mul_together();
        mul_start = 1'b1;
        div_start = 1'b1;
        mul_op = mul_op_e'($urandom_range(1, 0));
        div_op = div_op_e'($urandom_range(1, 0));
        mul_a = rand_word();
        mul_b = rand_word();
        div_a = rand_word();
        div_b = rand_word();
        mul_rd = 5'($urandom());
        div_rd = 5'($urandom());
        mul_pc = next_pc;
        expect_commit(mul_rd, ref_result(1'b0, mul_op, mul_a, mul_b), mul_pc, 1'b0);
        div_pc = next_pc;
        expect_commit(div_rd, ref_result(1'b1, div_op, div_a, div_b), div_pc, 1'b0);
        @(negedge clk);
        mul_start = 1'b0;
        div_start = 1'b0;
    endtask

    // ######################################################################
    // commit scoreboard and run limit
    // ######################################################################

    always @(posedge clk) begin
        if (!reset && commit_valid) begin
            commit_log.push_back(commit_pc);
            if (!sb.exists(commit_pc)) begin
                failures++;
                $display("commit with unknown pc %h", commit_pc);
            end else begin
                {e_rd, e_data, e_err} = sb[commit_pc];
                sb.delete(commit_pc);
                check_value("commit_rd", `XLEN'(commit_rd), `XLEN'(e_rd));
                check_value("commit_data", commit_data, e_data);
                check_value("commit_error", `XLEN'(commit_error), `XLEN'(e_err));
                if (!e_err && e_rd != 5'd0) shadow[e_rd] = e_data;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ######################################################################
    // test sequence
    // ######################################################################

    initial begin
        logic [`XLEN-1:0] divisor;
        {m_wen, m_mem_rd, m_error, data_rd_valid, data_rd_error} = '0;
        {m_rd, mul_rd, div_rd, rs_addr} = '0;
        {m_data, m_pc, data_rd} = '0;
        {mul_a, mul_b, mul_pc, div_a, div_b, div_pc} = '0;
        {mul_start, div_start} = '0;
        mul_op = MUL_LO;
        div_op = DIV_QU;
        next_pc = 64'h1000;
        for (int i = 0; i < `NREG; i++) shadow[i] = '0;
        void'($urandom(50));

        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        @(negedge reset);
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end

        for (int i = 0; i < 50; i++) issue_mul();
        wait_drain();

        for (int i = 0; i < 50; i++) begin
            if (i % 8 == 0) divisor = '0;
            else if (i % 8 == 1) divisor = `XLEN'(1);
            else if (i % 8 < 4) divisor = `XLEN'($urandom_range(1000, 2));
            else divisor = rand_word();
            issue_div(divisor);
        end
        wait_drain();

        for (int i = 0; i < 30; i++) issue_mem($urandom_range(1, 0) == 1, $urandom_range(6, 0));
        wait_drain();

        repeat (3) contention_round();

        for (int i = 0; i < `NREG; i++) begin
            rs_addr = 5'(i);
            @(posedge clk);
            check_value($sformatf("rs_data x%0d", i), rs_data, shadow[i]);
            @(negedge clk);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
wb_pkg.sv
wb_src_if.sv
mul_unit.sv
div_unit.sv
wb_arbiter.sv
regfile.sv
wb_top.sv
tb_clock.sv
tb_wb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_wb -o tb_wb_sim
./obj_dir/tb_wb_sim | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    exit 0
fi
exit 1
